// ==== dv/cpu_cases.txt ====
# case <name>, prog <16-bit hex words placed from 01_8000 upward>
# data <24-bit addr> <16-bit value> pairs, stores <24-bit addr> <16-bit value> in order
case alu_arith
prog 8264 85FD 8E40 8C42 2650 E7C0 3850 E980 9A50 EA40 F006
stores 000040 0061 000042 0067 000064 FED4
case alu_logic
prog 82F0 85AA 8E50 4650 E7C0 5850 E9C0 6A50 EBC0 F006
stores 000050 00A0 000050 FFFA 000050 FF5A
case br_zc
prog 8205 8407 8E60 8601 7050 C002 8600 E7C0 8601 7050 C202 8600 E7C0
prog 8601 7050 C402 8600 E7C0 8601 7050 C602 8600 E7C0 F006
stores 000060 0000 000060 0001 000060 0001 000060 0000
case br_nv
prog 8280 9248 2248 8401 8E62 8601 7050 C802 8600 E7C0 8601 7050 CA02 8600 E7C0
prog 8601 7050 CC02 8600 E7C0 8601 7050 CE02 8600 E7C0 F006
stores 000062 0000 000062 0001 000062 0001 000062 0000
case br_eq
prog 8209 8409 8E64 8601 7050 C002 8600 E7C0 8601 7050 C402 8600 E7C0
prog 8601 7050 C602 8600 E7C0 F006
stores 000064 0001 000064 0000 000064 0001
case load_store
prog 82F0 D440 8E70 E5C0 F006
data 0000F0 BEEF
stores 000070 BEEF
case dbr
prog 8205 1042 8E20 8411 E5C0 1603 E7C0 8800 1102 E7C0 F006
stores 050020 0011 050020 0005 000020 0005
case jumps
prog 8E30 8422 A00A E5C0 F006 E5C0 8A80 9B68 2B68 8C1C 2B70 B140 E5C0 F006 8433 E5C0 F006
stores 000030 0022 000030 0033

// ==== sim.f ====
logic/cpu_pkg.sv
logic/alu.sv
logic/fetch_unit.sv
logic/load_store_unit.sv
logic/mem_arbiter.sv
logic/exec_core.sv
logic/nc_cpu_top.sv
dv/cpu_properties.sv
dv/tb_cpu.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_cpu
FILELIST  ?= sim.f
LOG       ?= sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee $(LOG)
	grep -q "TB PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== dv/tb_cpu.sv ====
//====================
// CPU testbench
// Runs the programs from the cases file against the core with a
// wait-state memory model and checks the store sequence of each
//====================

`timescale 1ns/1ps

module tb_cpu;

    localparam cpu_pkg::addr_t PROG_BASE = 24'h01_8000;   // Reset fetch address
    localparam int    CLK_PERIOD       = 4;
    localparam int    RESET_CYCLES     = 8;
    localparam int    CYCLES_PER_INSTR = 24;   // Worst fetch plus data access
    localparam int    CASE_OVERHEAD    = 40;   // Reset and post-halt cycles
    localparam string CASES_FILE       = "dv/cpu_cases.txt";

    logic           clk;
    logic           reset_n;
    logic           mem_valid, mem_we, mem_ready, halted;
    cpu_pkg::addr_t mem_addr;
    cpu_pkg::word_t mem_wdata, mem_rdata;

    //====================
    // Case table
    //====================
    string          names[$];
    int             prog_start[$], prog_len[$], st_start[$], st_len[$];
    cpu_pkg::word_t prog_q[$];
    cpu_pkg::addr_t data_addr_q[$];
    cpu_pkg::word_t data_val_q[$];
    cpu_pkg::addr_t st_addr_q[$];
    cpu_pkg::word_t st_data_q[$];

    cpu_pkg::word_t mem [cpu_pkg::addr_t];
    cpu_pkg::addr_t wr_addr_log[$];
    cpu_pkg::word_t wr_data_log[$];
    logic [31:0]    lfsr_state = 32'h4c4c_90d0;
    int             wait_left;
    logic           counting;          // Wait count chosen for current request
    int             errors = 0;
    int             failed_cases = 0;
    longint         limit_ns = 0;      // Set once the cases are read

    nc_cpu_top i_dut (.*);

    bind nc_cpu_top cpu_properties i_props (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0])
            n = n ^ 32'h8020_0003;
        return n;
    endfunction

    // One LFSR step per bit taken
    function automatic int rand_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | int'(lfsr_state[0]);
            lfsr_state = lfsr_next(lfsr_state);
        end
        return v;
    endfunction

    function automatic cpu_pkg::word_t mem_read(input cpu_pkg::addr_t a);
        if (mem.exists(a))
            return mem[a];
        return {a[23:16], 8'h00} ^ a[15:0];   // Fill pattern
    endfunction

    //====================
    // Memory model
    //====================
    initial begin
        mem_ready = 1'b0;
        mem_rdata = '0;
        counting  = 1'b0;
        wait_left = 0;
        forever begin
            @(posedge clk);
            #1;
            if (!reset_n || !mem_valid) begin
                mem_ready = 1'b0;
                counting  = 1'b0;
            end else begin
                if (!counting) begin
                    wait_left = rand_bits(2);   // 0 to 3 wait cycles
                    counting  = 1'b1;
                end
                if (wait_left == 0) begin
                    mem_ready = 1'b1;
                    mem_rdata = mem_read(mem_addr);
                    counting  = 1'b0;
                end else begin
                    mem_ready = 1'b0;
                    wait_left--;
                end
            end
        end
    end

    // Completed writes, sampled mid-cycle
    initial begin
        forever begin
            @(negedge clk);
            if (reset_n && mem_valid && mem_ready && mem_we) begin
                mem[mem_addr] = mem_wdata;
                wr_addr_log.push_back(mem_addr);
                wr_data_log.push_back(mem_wdata);
            end
        end
    end

    task automatic check_addr(input string name, input int idx,
                              input cpu_pkg::addr_t expected, input cpu_pkg::addr_t actual);
        if (actual !== expected) begin
            $display("Mismatch %s store %0d address: expected %h, actual %h",
                     name, idx, expected, actual);
            errors++;
        end
    endtask

    task automatic check_word(input string name, input int idx,
                              input cpu_pkg::word_t expected, input cpu_pkg::word_t actual);
        if (actual !== expected) begin
            $display("Mismatch %s store %0d data: expected %h, actual %h",
                     name, idx, expected, actual);
            errors++;
        end
    endtask

    //====================
    // Cases file reader
    //====================
    task automatic load_cases();
        int               fd, code, mode, half, n;
        string            tok;
        logic [8*256-1:0] rest;
        logic [31:0]      val;
        fd = $fopen(CASES_FILE, "r");
        if (fd == 0) begin
            $display("Cannot open the cases file %s", CASES_FILE);
            errors++;
            return;
        end
        mode = 0;
        half = 0;
        while (!$feof(fd)) begin
            code = $fscanf(fd, "%s", tok);
            if (code != 1)
                break;
            n = names.size() - 1;
            if (tok.substr(0, 0) == "#") begin
                code = $fgets(rest, fd);   // Rest of a comment line
            end else if (tok == "case") begin
                code = $fscanf(fd, "%s", tok);
                names.push_back(tok);
                prog_start.push_back(prog_q.size());
                prog_len.push_back(0);
                st_start.push_back(st_addr_q.size());
                st_len.push_back(0);
                mode = 0;
            end else if (tok == "prog") begin
                mode = 1;
            end else if (tok == "data") begin
                mode = 2;
                half = 0;
            end else if (tok == "stores") begin
                mode = 3;
                half = 0;
            end else if (mode == 0 || n < 0) begin
                $display("Unexpected token %s in the cases file", tok);
                errors++;
            end else begin
                val = tok.atohex();
                if (mode == 1) begin
                    prog_q.push_back(val[15:0]);
                    prog_len[n] = prog_len[n] + 1;
                end else if (mode == 2) begin
                    if (half == 0)
                        data_addr_q.push_back(val[23:0]);
                    else
                        data_val_q.push_back(val[15:0]);
                    half = 1 - half;
                end else begin
                    if (half == 0) begin
                        st_addr_q.push_back(val[23:0]);
                        st_len[n] = st_len[n] + 1;
                    end else begin
                        st_data_q.push_back(val[15:0]);
                    end
                    half = 1 - half;
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic run_case(input int c);
        string name;
        int    first_err, n_exp, n_act, late_req;
        name      = names[c];
        first_err = errors;
        late_req  = 0;

        @(posedge clk);
        #1;
        reset_n = 1'b0;
        mem.delete();
        wr_addr_log.delete();
        wr_data_log.delete();
        for (int i = 0; i < prog_len[c]; i++)
            mem[PROG_BASE + cpu_pkg::addr_t'(2 * i)] = prog_q[prog_start[c] + i];
        for (int i = 0; i < data_addr_q.size(); i++)
            if (i < data_val_q.size() && data_owner(i) == c)
                mem[data_addr_q[i]] = data_val_q[i];
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset_n = 1'b1;

        do @(negedge clk); while (!halted);
        repeat (8) begin
            @(negedge clk);
            if (mem_valid || !halted)
                late_req++;
        end

        n_exp = st_len[c];
        n_act = wr_addr_log.size();
        for (int i = 0; i < n_exp && i < n_act; i++) begin
            check_addr(name, i, st_addr_q[st_start[c] + i], wr_addr_log[i]);
            check_word(name, i, st_data_q[st_start[c] + i], wr_data_log[i]);
        end
        if (n_act < n_exp) begin
            $display("%s: %0d expected stores never happened", name, n_exp - n_act);
            errors++;
        end
        if (n_act > n_exp) begin
            $display("%s: %0d stores happened that were not expected", name, n_act - n_exp);
            errors++;
        end
        if (late_req != 0) begin
            $display("%s: bus request seen or halted dropped after HALT", name);
            errors++;
        end

        if (errors == first_err) begin
            $display("case %-12s ok", name);
        end else begin
            $display("case %-12s failed with %0d errors", name, errors - first_err);
            failed_cases++;
        end
    endtask

    // Data words are tagged with their case in data_case_q
    int data_case_q[$];

    function automatic int data_owner(input int i);
        return data_case_q[i];
    endfunction

    //====================
    // Main sequence
    //====================
    initial begin
        int max_len;
        reset_n = 1'b0;
        load_cases();
        tag_data();
        max_len = 0;
        foreach (prog_len[i])
            if (prog_len[i] > max_len)
                max_len = prog_len[i];
        if (names.size() == 0) begin
            $display("No test cases were found");
            errors++;
        end else begin
            limit_ns = longint'(names.size()) *
                       (max_len * CYCLES_PER_INSTR + CASE_OVERHEAD) * CLK_PERIOD;
        end
        for (int c = 0; c < names.size(); c++)
            run_case(c);
        $display("%0d cases run, %0d failed, %0d errors", names.size(), failed_cases, errors);
        if (errors == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

    // Second pass over the file to tie each data word to its case
    task automatic tag_data();
        int    fd, code, cur;
        string tok;
        logic  in_data;
        logic [8*256-1:0] rest;
        fd = $fopen(CASES_FILE, "r");
        if (fd == 0)
            return;
        cur     = -1;
        in_data = 1'b0;
        while (!$feof(fd)) begin
            code = $fscanf(fd, "%s", tok);
            if (code != 1)
                break;
            if (tok.substr(0, 0) == "#") begin
                code = $fgets(rest, fd);
            end else if (tok == "case") begin
                code    = $fscanf(fd, "%s", tok);
                cur     = cur + 1;
                in_data = 1'b0;
            end else if (tok == "data") begin
                in_data = 1'b1;
            end else if (tok == "prog" || tok == "stores") begin
                in_data = 1'b0;
            end else if (in_data) begin
                data_case_q.push_back(cur);   // One tag per token, pairs share it
            end
        end
        $fclose(fd);
        // Keep one tag per address and value pair
        for (int i = 0; i < data_addr_q.size(); i++)
            data_case_q[i] = data_case_q[2 * i];
    endtask

    // Watchdog
    initial begin
        wait (limit_ns != 0);
        #(limit_ns);
        $display("Watchdog expired before all cases finished");
        $display("TB FAILED");
        $finish;
    end

endmodule

// ==== dv/cpu_properties.sv ====
//====================
// CPU bus properties
// Request stability, quiet bus after HALT and during reset
//====================

`timescale 1ns/1ps

module cpu_properties (
    input logic           clk,
    input logic           reset_n,
    input logic           mem_valid,
    input logic           mem_we,
    input cpu_pkg::addr_t mem_addr,
    input cpu_pkg::word_t mem_wdata,
    input logic           mem_ready,
    input logic           halted
);

    // Held request keeps its fields until mem_ready
    a_req_stable: assert property (@(posedge clk) disable iff (!reset_n)
        mem_valid && !mem_ready |=> mem_valid && $stable(mem_we) && $stable(mem_addr) &&
                                    (!mem_we || $stable(mem_wdata)))
        else $error("bus request changed while waiting for mem_ready");

    a_halt_quiet: assert property (@(posedge clk) disable iff (!reset_n)
        halted |-> !mem_valid)
        else $error("bus request while halted");

    a_reset_quiet: assert property (@(posedge clk) !reset_n |-> !mem_valid)
        else $error("bus request during reset");

endmodule

// ==== logic/nc_cpu_top.sv ====
//====================
// CPU top level
// Fetch, exec and load/store units sharing one memory bus
//====================

`timescale 1ns/1ps

module nc_cpu_top #(
    parameter cpu_pkg::bank_t RESET_BANK      = 8'h01,
    parameter cpu_pkg::word_t RESET_OFFSET    = 16'h8000,
    parameter cpu_pkg::bank_t RESET_DATA_BANK = 8'h00
) (
    input  logic           clk,
    input  logic           reset_n,
    output logic           mem_valid,
    output logic           mem_we,
    output cpu_pkg::addr_t mem_addr,
    output cpu_pkg::word_t mem_wdata,
    input  logic           mem_ready,
    input  cpu_pkg::word_t mem_rdata,
    output logic           halted
);

    // Fetch port
    logic           f_valid, f_ready;
    cpu_pkg::addr_t f_addr;
    cpu_pkg::word_t f_rdata;

    // Data port
    logic           d_valid, d_we, d_ready;
    cpu_pkg::addr_t d_addr;
    cpu_pkg::word_t d_wdata, d_rdata;

    // Fetch to exec
    logic            instr_valid, instr_ready;
    cpu_pkg::instr_u instr;
    cpu_pkg::word_t  instr_pc;
    logic            redirect;
    cpu_pkg::word_t  redirect_offset;

    // Exec to load/store unit
    logic           ls_valid, ls_we, ls_ready, ls_done;
    cpu_pkg::addr_t ls_addr;
    cpu_pkg::word_t ls_wdata, ls_rdata;

    fetch_unit #(
        .RESET_BANK   (RESET_BANK),
        .RESET_OFFSET (RESET_OFFSET)
    ) i_fetch (.*);

    exec_core #(
        .RESET_DATA_BANK (RESET_DATA_BANK)
    ) i_exec (.*);

    load_store_unit i_lsu (.*);

    mem_arbiter i_arb (.*);

endmodule

// ==== logic/exec_core.sv ====
//====================
// Execution core
// Decode, registers, flags, branches and LOAD/STORE sequencing
//====================

`timescale 1ns/1ps

module exec_core #(
    parameter cpu_pkg::bank_t RESET_DATA_BANK = 8'h00
) (
    input  logic            clk,
    input  logic            reset_n,
    input  logic            instr_valid,
    input  cpu_pkg::instr_u instr,
    input  cpu_pkg::word_t  instr_pc,
    output logic            instr_ready,
    output logic            redirect,
    output cpu_pkg::word_t  redirect_offset,
    output logic            ls_valid,
    output logic            ls_we,
    output cpu_pkg::addr_t  ls_addr,
    output cpu_pkg::word_t  ls_wdata,
    input  logic            ls_ready,
    input  logic            ls_done,
    input  cpu_pkg::word_t  ls_rdata,
    output logic            halted
);

    cpu_pkg::word_t    regs [8];
    logic [3:0]        flags;
    cpu_pkg::bank_t    dbr;
    logic              ls_wait;   // Data request issued, waiting for ls_done

    cpu_pkg::opcode_t  op;
    cpu_pkg::word_t    rs_val, rt_val, rd_val, imm_se;
    cpu_pkg::word_t    alu_b, alu_result;
    cpu_pkg::alu_op_t  alu_op;
    cpu_pkg::reg_idx_t wr_idx;
    logic              alu_carry, alu_overflow, cond_true, is_halt, mem_op, fire;
    logic              wr_en, set_zn, set_cv, dbr_wr, jump;

    assign op     = instr.r.opcode;
    assign rs_val = regs[instr.r.rs];
    assign rt_val = regs[instr.r.rt];
    assign rd_val = regs[instr.r.rd];
    assign imm_se = {{7{instr.i.imm[8]}}, instr.i.imm};
    assign wr_idx = (op == cpu_pkg::OP_MOVI) ? instr.i.sel : instr.r.rd;

    assign is_halt = (op == cpu_pkg::OP_SPECIAL) && (instr.r.func == cpu_pkg::FUNC_HALT);
    assign mem_op  = (op == cpu_pkg::OP_LOAD) || (op == cpu_pkg::OP_STORE);

    // HALT is never accepted, so the fetch buffer stays full
    assign instr_ready = !halted && (mem_op ? ls_done : !is_halt);
    assign fire        = instr_valid && instr_ready;
    assign redirect    = fire && jump;

    assign ls_valid = instr_valid && mem_op && !ls_wait;
    assign ls_we    = (op == cpu_pkg::OP_STORE);
    assign ls_addr  = {dbr, rs_val};
    assign ls_wdata = rd_val;

    always_comb begin
        cond_true = 1'b0;
        case (instr.i.sel)
            cpu_pkg::COND_EQ: cond_true =  flags[cpu_pkg::FLAG_Z];
            cpu_pkg::COND_NE: cond_true = !flags[cpu_pkg::FLAG_Z];
            cpu_pkg::COND_CS: cond_true =  flags[cpu_pkg::FLAG_C];
            cpu_pkg::COND_CC: cond_true = !flags[cpu_pkg::FLAG_C];
            cpu_pkg::COND_MI: cond_true =  flags[cpu_pkg::FLAG_N];
            cpu_pkg::COND_PL: cond_true = !flags[cpu_pkg::FLAG_N];
            cpu_pkg::COND_VS: cond_true =  flags[cpu_pkg::FLAG_V];
            cpu_pkg::COND_VC: cond_true = !flags[cpu_pkg::FLAG_V];
            default: cond_true = 1'b0;
        endcase
    end

    //====================
    // Decode
    //====================
    always_comb begin
        alu_op          = cpu_pkg::ALU_PASS;
        alu_b           = rt_val;
        wr_en           = 1'b0;
        set_zn          = 1'b0;
        set_cv          = 1'b0;
        dbr_wr          = 1'b0;
        jump            = 1'b0;
        redirect_offset = instr_pc + 16'd2;
        case (op)
            cpu_pkg::OP_ADD: begin alu_op = cpu_pkg::ALU_ADD; wr_en = 1'b1; set_cv = 1'b1; end
            cpu_pkg::OP_SUB: begin alu_op = cpu_pkg::ALU_SUB; wr_en = 1'b1; set_cv = 1'b1; end
            cpu_pkg::OP_CMP: begin alu_op = cpu_pkg::ALU_SUB; set_zn = 1'b1; set_cv = 1'b1; end
            cpu_pkg::OP_AND: begin alu_op = cpu_pkg::ALU_AND; wr_en = 1'b1; end
            cpu_pkg::OP_OR:  begin alu_op = cpu_pkg::ALU_OR;  wr_en = 1'b1; end
            cpu_pkg::OP_XOR: begin alu_op = cpu_pkg::ALU_XOR; wr_en = 1'b1; end
            cpu_pkg::OP_MUL: begin alu_op = cpu_pkg::ALU_MUL; wr_en = 1'b1; end
            cpu_pkg::OP_MOVI: begin alu_b = imm_se; wr_en = 1'b1; end
            cpu_pkg::OP_LOAD: begin alu_b = ls_rdata; wr_en = 1'b1; end
            cpu_pkg::OP_MOV: begin
                case (instr.r.func)
                    cpu_pkg::FUNC_MOV_RR:       begin alu_b = rs_val; wr_en = 1'b1; end
                    cpu_pkg::FUNC_MOV_FROM_DBR: begin alu_b = {8'h00, dbr}; wr_en = 1'b1; end
                    cpu_pkg::FUNC_MOV_TO_DBR:   dbr_wr = 1'b1;
                    default: ;                  // Unused variants act as NOP
                endcase
            end
            cpu_pkg::OP_JMPI: begin
                jump            = 1'b1;
                redirect_offset = {instr_pc[15:9], instr.i.imm};   // Same 512-byte page
            end
            cpu_pkg::OP_JMP: begin
                jump            = 1'b1;
                redirect_offset = rs_val;
            end
            cpu_pkg::OP_BRANCH: begin
                jump            = cond_true;
                redirect_offset = instr_pc + 16'd2 + imm_se;
            end
            default: ;                          // NOP, STORE, SPECIAL
        endcase
        if (wr_en)
            set_zn = 1'b1;
    end

    alu i_alu (
        .op       (alu_op),
        .a        (rs_val),
        .b        (alu_b),
        .result   (alu_result),
        .carry    (alu_carry),
        .overflow (alu_overflow)
    );

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < 8; i++)
                regs[i] <= '0;
            flags   <= '0;
            dbr     <= RESET_DATA_BANK;
            ls_wait <= 1'b0;
            halted  <= 1'b0;
        end else begin
            if (ls_valid && ls_ready)
                ls_wait <= 1'b1;
            else if (ls_done)
                ls_wait <= 1'b0;
            if (instr_valid && is_halt)
                halted <= 1'b1;
            if (fire) begin
                if (wr_en)
                    regs[wr_idx] <= alu_result;
                if (set_zn) begin
                    flags[cpu_pkg::FLAG_Z] <= (alu_result == 16'd0);
                    flags[cpu_pkg::FLAG_N] <= alu_result[15];
                end
                if (set_cv) begin
                    flags[cpu_pkg::FLAG_C] <= alu_carry;
                    flags[cpu_pkg::FLAG_V] <= alu_overflow;
                end
                if (dbr_wr)
                    dbr <= rs_val[7:0];
            end
        end
    end

endmodule

// ==== logic/mem_arbiter.sv ====
//====================
// Memory arbiter
// Data port first, grant held through wait states
//====================

`timescale 1ns/1ps

module mem_arbiter (
    input  logic           clk,
    input  logic           reset_n,
    input  logic           f_valid,
    input  cpu_pkg::addr_t f_addr,
    output logic           f_ready,
    output cpu_pkg::word_t f_rdata,
    input  logic           d_valid,
    input  logic           d_we,
    input  cpu_pkg::addr_t d_addr,
    input  cpu_pkg::word_t d_wdata,
    output logic           d_ready,
    output cpu_pkg::word_t d_rdata,
    output logic           mem_valid,
    output logic           mem_we,
    output cpu_pkg::addr_t mem_addr,
    output cpu_pkg::word_t mem_wdata,
    input  logic           mem_ready,
    input  cpu_pkg::word_t mem_rdata
);

    logic lock_valid, lock_data;
    logic owner_data;   // High when the data port owns the bus

    assign owner_data = lock_valid ? lock_data : d_valid;

    assign mem_valid = owner_data ? d_valid : f_valid;
    assign mem_we    = owner_data && d_we;   // Fetch port only reads
    assign mem_addr  = owner_data ? d_addr : f_addr;
    assign mem_wdata = d_wdata;

    assign f_ready = !owner_data && mem_ready;
    assign d_ready = owner_data && mem_ready;
    assign f_rdata = owner_data ? '0 : mem_rdata;
    assign d_rdata = owner_data ? mem_rdata : '0;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            lock_valid <= 1'b0;
            lock_data  <= 1'b0;
        end else begin
            lock_valid <= mem_valid && !mem_ready;   // Waiting, keep the owner
            if (mem_valid && !mem_ready)
                lock_data <= owner_data;
        end
    end

endmodule

// ==== logic/load_store_unit.sv ====
//====================
// Load/store unit
// Holds one data request on the data port until it completes
//====================

`timescale 1ns/1ps

module load_store_unit (
    input  logic           clk,
    input  logic           reset_n,
    input  logic           ls_valid,
    input  logic           ls_we,
    input  cpu_pkg::addr_t ls_addr,
    input  cpu_pkg::word_t ls_wdata,
    output logic           ls_ready,
    output logic           ls_done,
    output cpu_pkg::word_t ls_rdata,
    output logic           d_valid,
    output logic           d_we,
    output cpu_pkg::addr_t d_addr,
    output cpu_pkg::word_t d_wdata,
    input  logic           d_ready,
    input  cpu_pkg::word_t d_rdata
);

    logic busy;

    assign ls_ready = !busy;
    assign d_valid  = busy;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            busy    <= 1'b0;
            ls_done <= 1'b0;
        end else begin
            ls_done <= busy && d_ready;       // One cycle after bus completion
            if (ls_valid && ls_ready)
                busy <= 1'b1;
            else if (d_ready)
                busy <= 1'b0;
        end
    end

    // Request fields and read data
    always_ff @(posedge clk) begin
        if (ls_valid && ls_ready) begin
            d_we    <= ls_we;
            d_addr  <= ls_addr;
            d_wdata <= ls_wdata;
        end
        if (busy && d_ready && !d_we)
            ls_rdata <= d_rdata;
    end

endmodule

// ==== logic/fetch_unit.sv ====
//====================
// Fetch unit
// Program counter, one-entry prefetch buffer and redirect handling
//====================

`timescale 1ns/1ps

module fetch_unit #(
    parameter cpu_pkg::bank_t RESET_BANK   = 8'h01,
    parameter cpu_pkg::word_t RESET_OFFSET = 16'h8000
) (
    input  logic            clk,
    input  logic            reset_n,
    output logic            f_valid,
    output cpu_pkg::addr_t  f_addr,
    input  logic            f_ready,
    input  cpu_pkg::word_t  f_rdata,
    output logic            instr_valid,
    output cpu_pkg::instr_u instr,
    output cpu_pkg::word_t  instr_pc,
    input  logic            instr_ready,
    input  logic            redirect,
    input  cpu_pkg::word_t  redirect_offset
);

    logic            busy, stale, buf_valid;
    cpu_pkg::word_t  req_offset, fetch_pc, buf_pc, issue_offset;
    cpu_pkg::instr_u fetched, buf_instr;
    logic            accept, done, room, keep, fetched_halt, issue;

    assign fetched      = f_rdata;
    assign accept       = buf_valid && instr_ready;
    assign done         = busy && f_ready;
    assign room         = !buf_valid || accept;   // Buffer free next cycle
    assign keep         = done && !stale && !redirect && room;
    assign fetched_halt = (fetched.r.opcode == cpu_pkg::OP_SPECIAL) &&
                          (fetched.r.func == cpu_pkg::FUNC_HALT);
    // No prefetch past a HALT that is about to be buffered
    assign issue        = (!busy || done) && room && !(keep && fetched_halt);
    assign issue_offset = redirect ? redirect_offset : fetch_pc;

    assign f_valid     = busy;
    assign f_addr      = {RESET_BANK, req_offset};
    assign instr_valid = buf_valid;
    assign instr       = buf_instr;
    assign instr_pc    = buf_pc;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            busy       <= 1'b0;
            stale      <= 1'b0;
            buf_valid  <= 1'b0;
            req_offset <= RESET_OFFSET;
            fetch_pc   <= RESET_OFFSET;
        end else begin
            if (issue) begin
                busy       <= 1'b1;
                req_offset <= issue_offset;
                fetch_pc   <= issue_offset + 16'd2;
            end else begin
                if (done)
                    busy <= 1'b0;
                if (redirect)
                    fetch_pc <= redirect_offset;
                else if (done && !stale && !room)
                    fetch_pc <= req_offset;   // No room, replay this word later
            end

            if (redirect && busy && !done)
                stale <= 1'b1;                // Outstanding word is off-path
            else if (done)
                stale <= 1'b0;

            if (keep)
                buf_valid <= 1'b1;
            else if (accept || redirect)
                buf_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (keep) begin
            buf_instr <= fetched;
            buf_pc    <= req_offset;
        end
    end

endmodule

// ==== logic/alu.sv ====
//====================
// ALU
// 16-bit arithmetic and logic with carry and overflow
//====================

`timescale 1ns/1ps

module alu (
    input  cpu_pkg::alu_op_t op,
    input  cpu_pkg::word_t   a,
    input  cpu_pkg::word_t   b,
    output cpu_pkg::word_t   result,
    output logic             carry,
    output logic             overflow
);

    always_comb begin
        result   = '0;
        carry    = 1'b0;
        overflow = 1'b0;
        case (op)
            cpu_pkg::ALU_ADD: begin
                {carry, result} = {1'b0, a} + {1'b0, b};
                // Same input signs, result sign differs
                overflow = (a[15] == b[15]) && (result[15] != a[15]);
            end
            cpu_pkg::ALU_SUB: begin
                {carry, result} = {1'b0, a} - {1'b0, b};   // Carry is the borrow
                overflow = (a[15] != b[15]) && (result[15] != a[15]);
            end
            cpu_pkg::ALU_AND:  result = a & b;
            cpu_pkg::ALU_OR:   result = a | b;
            cpu_pkg::ALU_XOR:  result = a ^ b;
            cpu_pkg::ALU_MUL:  result = a * b;     // Low 16 bits only
            cpu_pkg::ALU_PASS: result = b;
            default:           result = b;
        endcase
    end

endmodule

// ==== logic/cpu_pkg.sv ====
//====================
// CPU package
// Shared widths, opcodes, instruction layout, flag and condition codes
//====================

package cpu_pkg;

    typedef logic [15:0] word_t;
    typedef logic [7:0]  bank_t;
    typedef logic [23:0] addr_t;   // Bank in [23:16], offset in [15:0]
    typedef logic [2:0]  reg_idx_t;

    typedef enum logic [3:0] {
        OP_NOP     = 4'h0,
        OP_MOV     = 4'h1,
        OP_ADD     = 4'h2,
        OP_SUB     = 4'h3,
        OP_AND     = 4'h4,
        OP_OR      = 4'h5,
        OP_XOR     = 4'h6,
        OP_CMP     = 4'h7,
        OP_MOVI    = 4'h8,
        OP_MUL     = 4'h9,
        OP_JMPI    = 4'hA,
        OP_JMP     = 4'hB,
        OP_BRANCH  = 4'hC,
        OP_LOAD    = 4'hD,
        OP_STORE   = 4'hE,
        OP_SPECIAL = 4'hF
    } opcode_t;

    //====================
    // Instruction views
    //====================
    typedef struct packed {
        opcode_t    opcode;
        reg_idx_t   rd;
        reg_idx_t   rs;
        reg_idx_t   rt;
        logic [2:0] func;   // MOV variant or SPECIAL function
    } instr_r_t;

    typedef struct packed {
        opcode_t    opcode;
        logic [2:0] sel;    // Destination or branch condition
        logic [8:0] imm;
    } instr_i_t;

    typedef union packed {
        instr_r_t r;
        instr_i_t i;
    } instr_u;

    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_MUL, ALU_PASS
    } alu_op_t;

    // Bit positions in the flag register
    localparam int FLAG_Z = 0;
    localparam int FLAG_N = 1;
    localparam int FLAG_C = 2;
    localparam int FLAG_V = 3;

    localparam logic [2:0] COND_EQ = 3'd0;
    localparam logic [2:0] COND_NE = 3'd1;
    localparam logic [2:0] COND_CS = 3'd2;
    localparam logic [2:0] COND_CC = 3'd3;
    localparam logic [2:0] COND_MI = 3'd4;
    localparam logic [2:0] COND_PL = 3'd5;
    localparam logic [2:0] COND_VS = 3'd6;
    localparam logic [2:0] COND_VC = 3'd7;

    localparam logic [2:0] FUNC_MOV_RR       = 3'd0;   // Rd <- Rs
    localparam logic [2:0] FUNC_MOV_TO_DBR   = 3'd2;   // DBR <- Rs
    localparam logic [2:0] FUNC_MOV_FROM_DBR = 3'd3;   // Rd <- DBR
    localparam logic [2:0] FUNC_HALT         = 3'd6;

endpackage
